// File: logic/rv_core_consts.svh
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// data and pc width.
`define XLEN 32

// rv32e register file.
`define REG_COUNT 16
`define REG_AW 4

// base opcodes of the supported instructions.
`define OP_LUI 7'b0110111
`define OP_AUIPC 7'b0010111
`define OP_JAL 7'b1101111
`define OP_JALR 7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_IMM 7'b0010011
`define OP_REG 7'b0110011

`endif

// File: logic/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_r_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_i_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} inst_s_t;

	typedef struct packed {
		logic imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic imm_11;
		logic [6:0] opcode;
	} inst_b_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_u_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} inst_j_t;

	// one instruction word, seen through each format.
	typedef union packed {
		inst_r_t r;
		inst_i_t i;
		inst_s_t s;
		inst_b_t b;
		inst_u_t u;
		inst_j_t j;
	} inst_u;

	typedef enum logic [2:0] {
		kind_lui,
		kind_auipc,
		kind_jal,
		kind_jalr,
		kind_beq,
		kind_addi,
		kind_add,
		kind_illegal
	} op_kind_e;

endpackage

`default_nettype wire

// File: logic/rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_decode (
	input wire logic clock,
	input wire logic rst,

	input wire logic in_valid,
	output logic in_ready,
	input wire logic [`XLEN-1:0] inst,
	input wire logic [`XLEN-1:0] pc,

	output logic [`REG_AW-1:0] rs1,
	output logic [`REG_AW-1:0] rs2,
	input wire logic [`XLEN-1:0] rs1_data,
	input wire logic [`XLEN-1:0] rs2_data,

	input wire logic ex_valid,
	input wire logic [`REG_AW-1:0] ex_rd,
	input wire logic redirect,

	output logic de_valid,
	output rv_core_pkg::op_kind_e de_kind,
	output logic [`REG_AW-1:0] de_rd,
	output logic [`XLEN-1:0] de_imm,
	output logic [`XLEN-1:0] de_pc,
	output logic [`XLEN-1:0] de_src1,
	output logic [`XLEN-1:0] de_src2
);

	rv_core_pkg::inst_u word;
	rv_core_pkg::op_kind_e kind;
	logic [`XLEN-1:0] imm;
	logic [`REG_AW-1:0] rd;
	logic has_rd;
	logic need_rs2;
	logic hit_de;
	logic hit_ex;
	logic stall;
	logic accept;

	assign word = inst;

	always_comb begin
		case (word.r.opcode)
			`OP_LUI: kind = rv_core_pkg::kind_lui;
			`OP_AUIPC: kind = rv_core_pkg::kind_auipc;
			`OP_JAL: kind = rv_core_pkg::kind_jal;
			`OP_JALR: kind = rv_core_pkg::kind_jalr;
			`OP_BRANCH: kind = rv_core_pkg::kind_beq;
			`OP_IMM: kind = rv_core_pkg::kind_addi;
			`OP_REG: kind = rv_core_pkg::kind_add;
			default: kind = rv_core_pkg::kind_illegal;
		endcase
	end

	// sign-extended immediate per format.
	always_comb begin
		case (kind)
			rv_core_pkg::kind_jalr,
			rv_core_pkg::kind_addi: begin
				imm = {{(`XLEN-12){word.i.imm[11]}}, word.i.imm};
			end
			rv_core_pkg::kind_lui,
			rv_core_pkg::kind_auipc: begin
				imm = {word.u.imm_31_12, 12'b0};
			end
			rv_core_pkg::kind_jal: begin
				imm = {{(`XLEN-21){word.j.imm_20}}, word.j.imm_20, word.j.imm_19_12,
					word.j.imm_11, word.j.imm_10_1, 1'b0};
			end
			rv_core_pkg::kind_beq: begin
				imm = {{(`XLEN-13){word.b.imm_12}}, word.b.imm_12, word.b.imm_11,
					word.b.imm_10_5, word.b.imm_4_1, 1'b0};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

	// rv32e keeps the low four bits of each index.
	assign rs1 = word.r.rs1[`REG_AW-1:0];
	assign rs2 = word.r.rs2[`REG_AW-1:0];

	// branches and unknown opcodes carry no destination.
	assign has_rd = (kind != rv_core_pkg::kind_beq) && (kind != rv_core_pkg::kind_illegal);
	assign rd = has_rd ? word.r.rd[`REG_AW-1:0] : '0;

	assign need_rs2 = (kind == rv_core_pkg::kind_add) || (kind == rv_core_pkg::kind_beq);

	assign hit_de = de_valid && (de_rd != '0) &&
		((de_rd == rs1) || (need_rs2 && (de_rd == rs2)));
	assign hit_ex = ex_valid && (ex_rd != '0) &&
		((ex_rd == rs1) || (need_rs2 && (ex_rd == rs2)));

	// wait until the producer has reached the register file.
	assign stall = hit_de || hit_ex;

	assign in_ready = !stall && !redirect;
	assign accept = in_valid && in_ready;

	always_ff @(posedge clock) begin
		if (rst) begin
			de_valid <= 1'b0;
		end else begin
			de_valid <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			de_kind <= kind;
			de_rd <= rd;
			de_imm <= imm;
			de_pc <= pc;
			de_src1 <= rs1_data;
			de_src2 <= rs2_data;
		end
	end

endmodule

`default_nettype wire

// File: logic/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_execute (
	input wire logic clock,
	input wire logic rst,

	input wire logic de_valid,
	input wire rv_core_pkg::op_kind_e de_kind,
	input wire logic [`REG_AW-1:0] de_rd,
	input wire logic [`XLEN-1:0] de_imm,
	input wire logic [`XLEN-1:0] de_pc,
	input wire logic [`XLEN-1:0] de_src1,
	input wire logic [`XLEN-1:0] de_src2,

	output logic ex_valid,
	output rv_core_pkg::op_kind_e ex_kind,
	output logic [`REG_AW-1:0] ex_rd,
	output logic [`XLEN-1:0] ex_data,
	output logic [`XLEN-1:0] ex_pc,

	output logic redirect,
	output logic [`XLEN-1:0] redirect_pc
);

	logic [`XLEN-1:0] pc_plus_imm;
	logic [`XLEN-1:0] pc_plus_4;
	logic [`XLEN-1:0] src1_plus_imm;
	logic [`XLEN-1:0] src_sum;
	logic [`XLEN-1:0] result;
	logic [`XLEN-1:0] target;
	logic taken;
	logic go;

	assign pc_plus_imm = de_pc + de_imm;
	assign pc_plus_4 = de_pc + `XLEN'd4;
	assign src1_plus_imm = de_src1 + de_imm;
	assign src_sum = de_src1 + de_src2;

	always_comb begin
		case (de_kind)
			rv_core_pkg::kind_lui: result = de_imm;
			rv_core_pkg::kind_auipc: result = pc_plus_imm;
			rv_core_pkg::kind_jal,
			rv_core_pkg::kind_jalr: result = pc_plus_4;
			rv_core_pkg::kind_addi: result = src1_plus_imm;
			rv_core_pkg::kind_add: result = src_sum;
			default: result = '0;
		endcase
	end

	// jalr target has bit 0 forced low.
	assign target = (de_kind == rv_core_pkg::kind_jalr) ?
		{src1_plus_imm[`XLEN-1:1], 1'b0} : pc_plus_imm;

	// predicted not-taken, so every taken transfer redirects.
	assign taken = (de_kind == rv_core_pkg::kind_jal) ||
		(de_kind == rv_core_pkg::kind_jalr) ||
		((de_kind == rv_core_pkg::kind_beq) && (de_src1 == de_src2));

	// the instruction behind a taken transfer is squashed here.
	assign go = de_valid && !redirect;

	always_ff @(posedge clock) begin
		if (rst) begin
			ex_valid <= 1'b0;
			redirect <= 1'b0;
		end else begin
			ex_valid <= go;
			redirect <= go && taken;
		end
	end

	always_ff @(posedge clock) begin
		if (go) begin
			ex_kind <= de_kind;
			ex_rd <= de_rd;
			ex_data <= result;
			ex_pc <= de_pc;
			redirect_pc <= target;
		end
	end

endmodule

`default_nettype wire

// File: logic/rv_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_result (
	input wire logic clock,
	input wire logic rst,

	input wire logic [`REG_AW-1:0] rs1,
	input wire logic [`REG_AW-1:0] rs2,
	output logic [`XLEN-1:0] rs1_data,
	output logic [`XLEN-1:0] rs2_data,

	input wire logic ex_valid,
	input wire rv_core_pkg::op_kind_e ex_kind,
	input wire logic [`REG_AW-1:0] ex_rd,
	input wire logic [`XLEN-1:0] ex_data,
	input wire logic [`XLEN-1:0] ex_pc,

	output logic wb_valid,
	output logic [`REG_AW-1:0] wb_rd,
	output logic [`XLEN-1:0] wb_data,
	output logic [`XLEN-1:0] wb_pc,
	output logic illegal
);

	logic [`XLEN-1:0] regs [`REG_COUNT];
	logic writes_rd;
	logic wr_en;

	// x0 is hardwired to zero.
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

	assign writes_rd = (ex_kind != rv_core_pkg::kind_beq) &&
		(ex_kind != rv_core_pkg::kind_illegal);
	assign wr_en = ex_valid && writes_rd && (ex_rd != '0);

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[ex_rd] <= ex_data;
		end
	end

	// report lines up with the write at the end of this cycle.
	assign wb_valid = wr_en;
	assign wb_rd = ex_rd;
	assign wb_data = ex_data;
	assign wb_pc = ex_pc;
	assign illegal = ex_valid && (ex_kind == rv_core_pkg::kind_illegal);

endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_core (
	input wire logic clock,
	input wire logic rst,

	input wire logic in_valid,
	output logic in_ready,
	input wire logic [`XLEN-1:0] inst,
	input wire logic [`XLEN-1:0] pc,

	output logic wb_valid,
	output logic [`REG_AW-1:0] wb_rd,
	output logic [`XLEN-1:0] wb_data,
	output logic [`XLEN-1:0] wb_pc,

	output logic redirect,
	output logic [`XLEN-1:0] redirect_pc,
	output logic illegal
);

	logic [`REG_AW-1:0] rs1;
	logic [`REG_AW-1:0] rs2;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;

	logic de_valid;
	rv_core_pkg::op_kind_e de_kind;
	logic [`REG_AW-1:0] de_rd;
	logic [`XLEN-1:0] de_imm;
	logic [`XLEN-1:0] de_pc;
	logic [`XLEN-1:0] de_src1;
	logic [`XLEN-1:0] de_src2;

	logic ex_valid;
	rv_core_pkg::op_kind_e ex_kind;
	logic [`REG_AW-1:0] ex_rd;
	logic [`XLEN-1:0] ex_data;
	logic [`XLEN-1:0] ex_pc;

	rv_decode u_decode (
		.clock(clock),
		.rst(rst),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.inst(inst),
		.pc(pc),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.ex_valid(ex_valid),
		.ex_rd(ex_rd),
		.redirect(redirect),
		.de_valid(de_valid),
		.de_kind(de_kind),
		.de_rd(de_rd),
		.de_imm(de_imm),
		.de_pc(de_pc),
		.de_src1(de_src1),
		.de_src2(de_src2)
	);

	rv_execute u_execute (
		.clock(clock),
		.rst(rst),
		.de_valid(de_valid),
		.de_kind(de_kind),
		.de_rd(de_rd),
		.de_imm(de_imm),
		.de_pc(de_pc),
		.de_src1(de_src1),
		.de_src2(de_src2),
		.ex_valid(ex_valid),
		.ex_kind(ex_kind),
		.ex_rd(ex_rd),
		.ex_data(ex_data),
		.ex_pc(ex_pc),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	rv_result u_result (
		.clock(clock),
		.rst(rst),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.ex_valid(ex_valid),
		.ex_kind(ex_kind),
		.ex_rd(ex_rd),
		.ex_data(ex_data),
		.ex_pc(ex_pc),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.wb_pc(wb_pc),
		.illegal(illegal)
	);

endmodule

`default_nettype wire

// File: sim/rv_core_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_core_props (
	input wire logic clock,
	input wire logic rst,
	input wire logic in_ready,
	input wire logic wb_valid,
	input wire logic [`REG_AW-1:0] wb_rd,
	input wire logic redirect,
	input wire logic illegal
);

	// register zero is never reported as written.
	wb_nonzero_rd: assert property (@(posedge clock) disable iff (rst)
		wb_valid |-> (wb_rd != '0))
		else $error("writeback reported for register zero");

	// no new instruction while a redirect is out.
	ready_low_on_redirect: assert property (@(posedge clock) disable iff (rst)
		redirect |-> !in_ready)
		else $error("in_ready high while redirect is high");

	// pipeline comes out of reset empty.
	quiet_after_reset: assert property (@(posedge clock)
		$fell(rst) |-> (!redirect && !wb_valid && !illegal))
		else $error("pulse seen in the first cycle after reset");

endmodule

`default_nettype wire

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module rv_core_tb;

	logic clock = 1'b0;
	logic rst = 1'b1;
	logic in_valid = 1'b0;
	logic [`XLEN-1:0] inst = '0;
	logic [`XLEN-1:0] pc = '0;
	logic in_ready;
	logic wb_valid;
	logic [`REG_AW-1:0] wb_rd;
	logic [`XLEN-1:0] wb_data;
	logic [`XLEN-1:0] wb_pc;
	logic redirect;
	logic [`XLEN-1:0] redirect_pc;
	logic illegal;

	logic [31:0] prog [$];
	logic running = 1'b0;
	logic [31:0] fetch_pc = '0;
	logic [31:0] next_pc;
	logic [31:0] marker_pc = '1;
	logic accept_s = 1'b0;
	logic redirect_s = 1'b0;
	logic [31:0] target_s = '0;
	logic marker_seen = 1'b0;
	logic [67:0] exp_wb [$];
	logic [67:0] act_wb [$];
	logic [31:0] exp_redir [$];
	logic [31:0] act_redir [$];
	logic [31:0] exp_ill [$];
	logic [31:0] act_ill [$];
	int errors = 0;
	int tests = 0;
	int failed_tests = 0;

	rv_core u_rv_core (
		.clock(clock), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
		.inst(inst), .pc(pc), .wb_valid(wb_valid), .wb_rd(wb_rd),
		.wb_data(wb_data), .wb_pc(wb_pc), .redirect(redirect),
		.redirect_pc(redirect_pc), .illegal(illegal)
	);

	bind rv_core rv_core_props u_props (
		.clock(clock), .rst(rst), .in_ready(in_ready), .wb_valid(wb_valid),
		.wb_rd(wb_rd), .redirect(redirect), .illegal(illegal)
	);

	always #5 clock = ~clock;

	// sample settled outputs away from the active edge.
	always @(negedge clock) begin
		accept_s = in_valid && in_ready;
		redirect_s = redirect;
		target_s = redirect_pc;
		if (!rst) begin
			if (wb_valid === 1'b1)
				act_wb.push_back({wb_rd, wb_data, wb_pc});
			if (redirect === 1'b1)
				act_redir.push_back(redirect_pc);
			if (illegal === 1'b1)
				act_ill.push_back(wb_pc);
			if ((wb_valid === 1'b1 || illegal === 1'b1) && wb_pc == marker_pc)
				marker_seen = 1'b1;
		end
	end

	// fetcher model, holds a word until accepted and follows redirects.
	always @(posedge clock) begin
		if (rst || !running) begin
			fetch_pc <= '0;
			in_valid <= 1'b0;
		end else begin
			next_pc = fetch_pc;
			if (redirect_s)
				next_pc = target_s;
			else if (accept_s)
				next_pc = fetch_pc + 4;
			fetch_pc <= next_pc;
			in_valid <= (next_pc >> 2) < prog.size();
			inst <= ((next_pc >> 2) < prog.size()) ? prog[next_pc >> 2] : '0;
			pc <= next_pc;
		end
	end

	function automatic logic [31:0] i_type(logic [6:0] op, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], op};
	endfunction

	function automatic logic [31:0] u_type(logic [6:0] op, int rd, int imm);
		return {imm[19:0], rd[4:0], op};
	endfunction

	function automatic logic [31:0] jal_word(int rd, int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `OP_JAL};
	endfunction

	function automatic logic [31:0] beq_word(int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], `OP_BRANCH};
	endfunction

	function automatic logic [31:0] add_word(int rd, int rs1, int rs2);
		return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], `OP_REG};
	endfunction

	// in-order reference, runs the program up to the final instruction.
	task automatic run_model();
		logic [31:0] regs [16];
		logic [31:0] mpc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] data;
		logic [31:0] next;
		logic [31:0] imm_i;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [31:0] imm_b;
		logic [3:0] rd;
		logic wr;
		logic taken;
		rv_core_pkg::op_kind_e kind;
		for (int r = 0; r < 16; r++)
			regs[r] = '0;
		mpc = '0;
		for (int step = 0; step < 2000; step++) begin
			w = prog[mpc >> 2];
			a = regs[w[18:15]];
			b = regs[w[23:20]];
			rd = w[10:7];
			imm_i = {{20{w[31]}}, w[31:20]};
			imm_u = {w[31:12], 12'b0};
			imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			case (w[6:0])
				`OP_LUI: kind = rv_core_pkg::kind_lui;
				`OP_AUIPC: kind = rv_core_pkg::kind_auipc;
				`OP_JAL: kind = rv_core_pkg::kind_jal;
				`OP_JALR: kind = rv_core_pkg::kind_jalr;
				`OP_BRANCH: kind = rv_core_pkg::kind_beq;
				`OP_IMM: kind = rv_core_pkg::kind_addi;
				`OP_REG: kind = rv_core_pkg::kind_add;
				default: kind = rv_core_pkg::kind_illegal;
			endcase
			next = mpc + 4;
			wr = 1'b1;
			taken = 1'b0;
			data = '0;
			case (kind)
				rv_core_pkg::kind_lui: data = imm_u;
				rv_core_pkg::kind_auipc: data = mpc + imm_u;
				rv_core_pkg::kind_jal: begin
					data = mpc + 4;
					next = mpc + imm_j;
					taken = 1'b1;
				end
				rv_core_pkg::kind_jalr: begin
					data = mpc + 4;
					next = (a + imm_i) & ~32'd1;
					taken = 1'b1;
				end
				rv_core_pkg::kind_beq: begin
					wr = 1'b0;
					taken = (a == b);
					next = taken ? mpc + imm_b : mpc + 4;
				end
				rv_core_pkg::kind_addi: data = a + imm_i;
				rv_core_pkg::kind_add: data = a + b;
				default: begin
					wr = 1'b0;
					exp_ill.push_back(mpc);
				end
			endcase
			if (taken)
				exp_redir.push_back(next);
			if (wr && rd != 0) begin
				exp_wb.push_back({rd, data, mpc});
				regs[rd] = data;
			end
			if (mpc == marker_pc)
				break;
			mpc = next;
		end
	endtask

	task automatic check_value(string test, string what, logic [31:0] expected,
			logic [31:0] actual);
		assert (expected === actual)
		else begin
			$display("mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_results(string test);
		check_value(test, "writeback count", exp_wb.size(), act_wb.size());
		check_value(test, "redirect count", exp_redir.size(), act_redir.size());
		check_value(test, "illegal count", exp_ill.size(), act_ill.size());
		for (int i = 0; i < exp_wb.size() && i < act_wb.size(); i++) begin
			check_value(test, $sformatf("wb %0d rd", i), exp_wb[i][67:64], act_wb[i][67:64]);
			check_value(test, $sformatf("wb %0d data", i), exp_wb[i][63:32], act_wb[i][63:32]);
			check_value(test, $sformatf("wb %0d pc", i), exp_wb[i][31:0], act_wb[i][31:0]);
		end
		for (int i = 0; i < exp_redir.size() && i < act_redir.size(); i++)
			check_value(test, $sformatf("redirect %0d target", i), exp_redir[i], act_redir[i]);
		for (int i = 0; i < exp_ill.size() && i < act_ill.size(); i++)
			check_value(test, $sformatf("illegal %0d pc", i), exp_ill[i], act_ill[i]);
	endtask

	task automatic finish_test(string test, int start_errors);
		tests++;
		if (errors == start_errors) begin
			$display("test %s: ok", test);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", test, errors - start_errors);
		end
	endtask

	task automatic reset_dut();
		@(negedge clock);
		running = 1'b0;
		@(posedge clock);
		rst <= 1'b1;
		repeat (10) @(posedge clock);
		rst <= 1'b0;
	endtask

	task automatic run_program(string test);
		int start_errors;
		int cycles;
		start_errors = errors;
		reset_dut();
		@(negedge clock);
		marker_pc = (prog.size() - 1) * 4;
		exp_wb.delete();
		act_wb.delete();
		exp_redir.delete();
		act_redir.delete();
		exp_ill.delete();
		act_ill.delete();
		marker_seen = 1'b0;
		run_model();
		running = 1'b1;
		cycles = 0;
		while (!marker_seen && cycles < 5000) begin
			@(posedge clock);
			cycles++;
		end
		assert (marker_seen)
		else begin
			$display("timeout in %s: instruction at pc %h never retired", test, marker_pc);
			errors++;
		end
		// let any stray writeback show up.
		repeat (4) @(posedge clock);
		compare_results(test);
		finish_test(test, start_errors);
		prog.delete();
	endtask

	task automatic reset_state();
		int start_errors;
		start_errors = errors;
		reset_dut();
		@(negedge clock);
		check_value("reset_state", "in_ready", 1, in_ready);
		check_value("reset_state", "wb_valid", 0, wb_valid);
		check_value("reset_state", "redirect", 0, redirect);
		check_value("reset_state", "illegal", 0, illegal);
		finish_test("reset_state", start_errors);
	endtask

	task automatic dependent_alu();
		prog.push_back(u_type(`OP_LUI, 1, 'h12345));
		prog.push_back(u_type(`OP_AUIPC, 2, 'h1));
		prog.push_back(i_type(`OP_IMM, 3, 1, -1));
		prog.push_back(add_word(4, 3, 2));
		prog.push_back(i_type(`OP_IMM, 5, 4, 'h7ff));
		prog.push_back(add_word(6, 5, 1));
		run_program("dependent_alu");
	endtask

	task automatic branch_paths();
		prog.push_back(i_type(`OP_IMM, 1, 0, 5));
		prog.push_back(i_type(`OP_IMM, 2, 0, 5));
		prog.push_back(beq_word(1, 2, 12));
		prog.push_back(i_type(`OP_IMM, 3, 0, 1));
		prog.push_back(i_type(`OP_IMM, 4, 0, 2));
		prog.push_back(beq_word(1, 0, 8));
		prog.push_back(i_type(`OP_IMM, 5, 0, 3));
		prog.push_back(i_type(`OP_IMM, 6, 5, 4));
		run_program("branch_paths");
	endtask

	task automatic jump_links();
		prog.push_back(jal_word(1, 12));
		prog.push_back(i_type(`OP_IMM, 2, 0, 9));
		prog.push_back(i_type(`OP_IMM, 3, 0, 9));
		prog.push_back(i_type(`OP_IMM, 4, 0, 'h21));
		// odd target, bit 0 must be dropped.
		prog.push_back(i_type(`OP_JALR, 5, 4, 0));
		prog.push_back(i_type(`OP_IMM, 6, 0, 1));
		prog.push_back(i_type(`OP_IMM, 8, 0, 8));
		prog.push_back(i_type(`OP_IMM, 8, 0, 8));
		prog.push_back(i_type(`OP_IMM, 7, 5, 1));
		run_program("jump_links");
	endtask

	task automatic illegal_opcode();
		prog.push_back(i_type(`OP_IMM, 1, 0, 7));
		prog.push_back(32'h0000_000b);
		prog.push_back(i_type(`OP_IMM, 2, 1, 1));
		prog.push_back(add_word(3, 2, 1));
		run_program("illegal_opcode");
	endtask

	task automatic random_alu();
		int rd;
		int rs1;
		int rs2;
		for (int n = 0; n < 200; n++) begin
			rd = 1 + ($urandom % 15);
			rs1 = $urandom % 16;
			rs2 = $urandom % 16;
			if ($urandom % 2 == 0)
				prog.push_back(i_type(`OP_IMM, rd, rs1, $urandom));
			else
				prog.push_back(add_word(rd, rs1, rs2));
		end
		run_program("random_alu");
	endtask

	initial begin
		repeat (60000) @(posedge clock);
		$display("watchdog expired before the tests finished");
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		void'($urandom(46));
		reset_state();
		dependent_alu();
		branch_paths();
		jump_links();
		illegal_opcode();
		random_alu();
		$display("tests run: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/rv_core_pkg.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core.sv
sim/rv_core_props.sv
sim/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_core_pkg.sv
      - logic/rv_decode.sv
      - logic/rv_execute.sv
      - logic/rv_result.sv
      - logic/rv_core.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/rv_core_props.sv
      - sim/rv_core_tb.sv
